//--- design/gpio_cfg_pkg.sv
package gpio_cfg_pkg;

  // Board target with 12 P/N pairs on the user header
  // Mapping folds host bits in groups of two pairs, so this stays even
  localparam int GPIO_PAIRS = 12;

  // Single-ended use gives two host signals per pair
  localparam int GPIO_SIGS = 2 * GPIO_PAIRS;

  // Host data bus and register width
  // Bits GPIO_SIGS and up have no pad behind them and loop back
  localparam int HOST_WIDTH = 32;

  // Word address into the eight-entry register file
  localparam int ADDR_WIDTH = 3;

endpackage

//--- design/gpio_reg_pkg.sv
package gpio_reg_pkg;

  import gpio_cfg_pkg::*;

  // Register map, one word per address
  localparam logic [ADDR_WIDTH-1:0] REG_OUT      = 3'd0; // Output value, R/W
  localparam logic [ADDR_WIDTH-1:0] REG_TRI      = 3'd1; // Tristate, 1 = input
  localparam logic [ADDR_WIDTH-1:0] REG_IN       = 3'd2; // Synced pins, RO
  localparam logic [ADDR_WIDTH-1:0] REG_OUT_SET  = 3'd3; // Ones set out bits, WO
  localparam logic [ADDR_WIDTH-1:0] REG_OUT_CLR  = 3'd4; // Ones clear out bits, WO
  localparam logic [ADDR_WIDTH-1:0] REG_IRQ_EN   = 3'd5; // Interrupt enable
  localparam logic [ADDR_WIDTH-1:0] REG_IRQ_POL  = 3'd6; // 1 = rising, 0 = falling
  localparam logic [ADDR_WIDTH-1:0] REG_IRQ_STAT = 3'd7; // Sticky, W1C

  // All pins come up as inputs
  localparam logic [HOST_WIDTH-1:0] TRI_RESET = '1;

  // Output latch starts low so pads drive low once enabled
  localparam logic [HOST_WIDTH-1:0] OUT_RESET = '0;

  // Interrupt enable, polarity and status all start cleared
  localparam logic [HOST_WIDTH-1:0] IRQ_RESET = '0;

endpackage

//--- design/gpio_ctrl.sv
`timescale 1ns/1ns

module gpio_ctrl
  import gpio_cfg_pkg::*, gpio_reg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Host side, four-phase req/ack
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [HOST_WIDTH-1:0] wdata_i,
  output logic                  ack_o,
  output logic [HOST_WIDTH-1:0] rdata_o,
  // Single-cycle write strobes to the datapath
  output logic                  out_we_o,
  output logic                  tri_we_o,
  output logic                  set_we_o,
  output logic                  clr_we_o,
  output logic                  en_we_o,
  output logic                  pol_we_o,
  output logic                  stat_clr_we_o,
  output logic [HOST_WIDTH-1:0] wdata_o,
  // Register values back for the read mux
  input  logic [HOST_WIDTH-1:0] out_val_i,
  input  logic [HOST_WIDTH-1:0] tri_val_i,
  input  logic [HOST_WIDTH-1:0] in_val_i,
  input  logic [HOST_WIDTH-1:0] en_val_i,
  input  logic [HOST_WIDTH-1:0] pol_val_i,
  input  logic [HOST_WIDTH-1:0] stat_val_i
);

  typedef enum logic [1:0] {
    ST_IDLE,   // Waiting for req
    ST_ACCESS, // Strobe or capture issued here
    ST_ACK     // Ack raised, wait for req to drop
  } state_t;

  state_t                state_q;
  logic [HOST_WIDTH-1:0] rd_mux;

  // Read mux, write-only addresses give zero
  always_comb begin
    case (addr_i)
      REG_OUT:      rd_mux = out_val_i;
      REG_TRI:      rd_mux = tri_val_i;
      REG_IN:       rd_mux = in_val_i;
      REG_IRQ_EN:   rd_mux = en_val_i;
      REG_IRQ_POL:  rd_mux = pol_val_i;
      REG_IRQ_STAT: rd_mux = stat_val_i;
      default:      rd_mux = '0; // SET and CLR aliases
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= ST_IDLE;
      ack_o         <= 1'b0;
      out_we_o      <= 1'b0;
      tri_we_o      <= 1'b0;
      set_we_o      <= 1'b0;
      clr_we_o      <= 1'b0;
      en_we_o       <= 1'b0;
      pol_we_o      <= 1'b0;
      stat_clr_we_o <= 1'b0;
    end else begin
      // Strobes default low so each lasts one cycle
      out_we_o      <= 1'b0;
      tri_we_o      <= 1'b0;
      set_we_o      <= 1'b0;
      clr_we_o      <= 1'b0;
      en_we_o       <= 1'b0;
      pol_we_o      <= 1'b0;
      stat_clr_we_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_i) state_q <= ST_ACCESS;
        end
        ST_ACCESS: begin
          state_q <= ST_ACK;
          if (we_i) begin // REG_IN writes match nothing and are dropped
            out_we_o      <= (addr_i == REG_OUT);
            tri_we_o      <= (addr_i == REG_TRI);
            set_we_o      <= (addr_i == REG_OUT_SET);
            clr_we_o      <= (addr_i == REG_OUT_CLR);
            en_we_o       <= (addr_i == REG_IRQ_EN);
            pol_we_o      <= (addr_i == REG_IRQ_POL);
            stat_clr_we_o <= (addr_i == REG_IRQ_STAT);
          end
        end
        ST_ACK: begin
          if (!req_i) begin // Host released, close the handshake
            ack_o   <= 1'b0;
            state_q <= ST_IDLE;
          end else begin
            ack_o   <= 1'b1; // Same edge the strobe lands in the registers
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Data path of the handshake
  always_ff @(posedge clk_i) begin
    if (state_q == ST_ACCESS) wdata_o <= wdata_i;
    // Capture once, on the edge raising ack, then hold
    if (state_q == ST_ACK && !ack_o && req_i && !we_i) rdata_o <= rd_mux;
  end

  // Ack only ever answers a pending request
  a_ack_needs_req : assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_o) |-> $past(req_i));

  // One register touched per handshake
  a_one_strobe : assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({out_we_o, tri_we_o, set_we_o, clr_we_o, en_we_o, pol_we_o, stat_clr_we_o}));

endmodule

//--- design/gpio_out_regs.sv
`timescale 1ns/1ns

module gpio_out_regs
  import gpio_cfg_pkg::*, gpio_reg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  out_we_i,  // Plain write of REG_OUT
  input  logic                  tri_we_i,  // Plain write of REG_TRI
  input  logic                  set_we_i,  // OR into output
  input  logic                  clr_we_i,  // AND NOT into output
  input  logic [HOST_WIDTH-1:0] wdata_i,
  output logic [HOST_WIDTH-1:0] out_val_o,
  output logic [HOST_WIDTH-1:0] tri_val_o
);

  logic [HOST_WIDTH-1:0] out_q;
  logic [HOST_WIDTH-1:0] tri_q;

  // Output latch with set/clear aliases
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q <= OUT_RESET;
    end else if (out_we_i) begin
      out_q <= wdata_i;
    end else if (set_we_i) begin
      out_q <= out_q | wdata_i;  // Ones set
    end else if (clr_we_i) begin
      out_q <= out_q & ~wdata_i; // Ones clear
    end
  end

  // Tristate, all inputs out of reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tri_q <= TRI_RESET;
    end else if (tri_we_i) begin
      tri_q <= wdata_i;
    end
  end

  assign out_val_o = out_q;
  assign tri_val_o = tri_q;

  // Aliases are separate addresses, so never both at once
  a_set_clr_excl : assert property (@(posedge clk_i) disable iff (rst_i)
    !(set_we_i && clr_we_i));

endmodule

//--- design/gpio_in_edge.sv
`timescale 1ns/1ns

module gpio_in_edge
  import gpio_cfg_pkg::*, gpio_reg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [HOST_WIDTH-1:0] pin_i,        // Async pin values from pin map
  input  logic                  en_we_i,
  input  logic                  pol_we_i,
  input  logic                  stat_clr_we_i,
  input  logic [HOST_WIDTH-1:0] wdata_i,
  output logic [HOST_WIDTH-1:0] in_val_o,
  output logic [HOST_WIDTH-1:0] en_val_o,
  output logic [HOST_WIDTH-1:0] pol_val_o,
  output logic [HOST_WIDTH-1:0] stat_val_o,
  output logic                  irq_o
);

  logic [HOST_WIDTH-1:0] sync1_q, sync2_q; // Two-flop synchronizer
  logic [HOST_WIDTH-1:0] prev_q;           // Last synced value for edge detect
  logic [HOST_WIDTH-1:0] en_q, pol_q, stat_q;
  logic [HOST_WIDTH-1:0] rise, fall, hit;
  logic [HOST_WIDTH-1:0] clr_mask;

  assign rise     = sync2_q & ~prev_q;
  assign fall     = ~sync2_q & prev_q;
  assign hit      = (pol_q & rise) | (~pol_q & fall); // Polarity picks the edge
  assign clr_mask = stat_clr_we_i ? wdata_i : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      en_q    <= IRQ_RESET;
      pol_q   <= IRQ_RESET;
      stat_q  <= IRQ_RESET;
    end else begin
      sync1_q <= pin_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (en_we_i) en_q <= wdata_i;
      if (pol_we_i) pol_q <= wdata_i;
      // Edge after clear, so a fresh edge survives a same-cycle W1C
      stat_q <= (stat_q & ~clr_mask) | hit;
    end
  end

  assign in_val_o   = sync2_q;
  assign en_val_o   = en_q;
  assign pol_val_o  = pol_q;
  assign stat_val_o = stat_q;
  assign irq_o      = |(stat_q & en_q); // Masked status, no extra flop

  // Interrupt line only with an enabled pending bit
  a_irq_source : assert property (@(posedge clk_i) disable iff (rst_i)
    irq_o |-> (stat_val_o & en_val_o) != '0);

endmodule

//--- design/gpio_pin_map.sv
`timescale 1ns/1ns

module gpio_pin_map
  import gpio_cfg_pkg::*;
(
  input  logic [HOST_WIDTH-1:0] out_val_i,  // Host-side output values
  input  logic [HOST_WIDTH-1:0] tri_val_i,  // Host-side tristate, 1 = input
  output logic [HOST_WIDTH-1:0] pin_o,      // Host-side pin readback
  input  logic [GPIO_PAIRS-1:0] pad_n_i,
  input  logic [GPIO_PAIRS-1:0] pad_p_i,
  output logic [GPIO_PAIRS-1:0] pad_n_o,
  output logic [GPIO_PAIRS-1:0] pad_p_o,
  output logic [GPIO_PAIRS-1:0] pad_n_oe_o,
  output logic [GPIO_PAIRS-1:0] pad_p_oe_o
);

  // Interleave works on two pairs at a time
  if (GPIO_PAIRS % 2 != 0) begin : g_bad_pairs
    $error("GPIO_PAIRS must be even");
  end

  // Per group: host 2m,2m+1 on N pairs m,m+1; host 2m+2,2m+3 on P pairs m,m+1
  for (genvar m = 0; m < GPIO_PAIRS; m += 2) begin : g_pair_grp
    // Pads to host
    assign pin_o[2*m]   = pad_n_i[m];
    assign pin_o[2*m+1] = pad_n_i[m+1];
    assign pin_o[2*m+2] = pad_p_i[m];
    assign pin_o[2*m+3] = pad_p_i[m+1];

    // Host to pad drivers
    assign pad_n_o[m]   = out_val_i[2*m];
    assign pad_n_o[m+1] = out_val_i[2*m+1];
    assign pad_p_o[m]   = out_val_i[2*m+2];
    assign pad_p_o[m+1] = out_val_i[2*m+3];

    // Enable is active high, tristate bit is active high for input
    assign pad_n_oe_o[m]   = ~tri_val_i[2*m];
    assign pad_n_oe_o[m+1] = ~tri_val_i[2*m+1];
    assign pad_p_oe_o[m]   = ~tri_val_i[2*m+2];
    assign pad_p_oe_o[m+1] = ~tri_val_i[2*m+3];
  end

  // No pad behind the upper host bits, read back what would be driven
  assign pin_o[HOST_WIDTH-1:GPIO_SIGS] = out_val_i[HOST_WIDTH-1:GPIO_SIGS]
                                       & ~tri_val_i[HOST_WIDTH-1:GPIO_SIGS];

endmodule

//--- design/gpio_top.sv
`timescale 1ns/1ns

module gpio_top
  import gpio_cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Host bus
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [HOST_WIDTH-1:0] wdata_i,
  output logic                  ack_o,
  output logic [HOST_WIDTH-1:0] rdata_o,
  // Header pads, board buffers sit outside
  input  logic [GPIO_PAIRS-1:0] pad_n_i,
  input  logic [GPIO_PAIRS-1:0] pad_p_i,
  output logic [GPIO_PAIRS-1:0] pad_n_o,
  output logic [GPIO_PAIRS-1:0] pad_p_o,
  output logic [GPIO_PAIRS-1:0] pad_n_oe_o,
  output logic [GPIO_PAIRS-1:0] pad_p_oe_o,
  output logic                  irq_o
);

  logic                  out_we, tri_we, set_we, clr_we;   // To output regs
  logic                  en_we, pol_we, stat_clr_we;       // To input path
  logic [HOST_WIDTH-1:0] wdata;
  logic [HOST_WIDTH-1:0] out_val, tri_val;
  logic [HOST_WIDTH-1:0] in_val, en_val, pol_val, stat_val;
  logic [HOST_WIDTH-1:0] pin_in;                           // Pads plus loopback

  gpio_ctrl i_gpio_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .ack_o         (ack_o),
    .rdata_o       (rdata_o),
    .out_we_o      (out_we),
    .tri_we_o      (tri_we),
    .set_we_o      (set_we),
    .clr_we_o      (clr_we),
    .en_we_o       (en_we),
    .pol_we_o      (pol_we),
    .stat_clr_we_o (stat_clr_we),
    .wdata_o       (wdata),
    .out_val_i     (out_val),
    .tri_val_i     (tri_val),
    .in_val_i      (in_val),
    .en_val_i      (en_val),
    .pol_val_i     (pol_val),
    .stat_val_i    (stat_val)
  );

  gpio_out_regs i_gpio_out_regs (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .out_we_i  (out_we),
    .tri_we_i  (tri_we),
    .set_we_i  (set_we),
    .clr_we_i  (clr_we),
    .wdata_i   (wdata),
    .out_val_o (out_val),
    .tri_val_o (tri_val)
  );

  gpio_in_edge i_gpio_in_edge (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .pin_i         (pin_in),
    .en_we_i       (en_we),
    .pol_we_i      (pol_we),
    .stat_clr_we_i (stat_clr_we),
    .wdata_i       (wdata),
    .in_val_o      (in_val),
    .en_val_o      (en_val),
    .pol_val_o     (pol_val),
    .stat_val_o    (stat_val),
    .irq_o         (irq_o)
  );

  // Board-specific fold onto the N/P header
  gpio_pin_map i_gpio_pin_map (
    .out_val_i  (out_val),
    .tri_val_i  (tri_val),
    .pin_o      (pin_in),
    .pad_n_i    (pad_n_i),
    .pad_p_i    (pad_p_i),
    .pad_n_o    (pad_n_o),
    .pad_p_o    (pad_p_o),
    .pad_n_oe_o (pad_n_oe_o),
    .pad_p_oe_o (pad_p_oe_o)
  );

endmodule

//--- tests/gpio_tb.sv
`timescale 1ns/1ns

module gpio_tb
  import gpio_cfg_pkg::*, gpio_reg_pkg::*;
;

  localparam int MAX_CYCLES = 3000; // Roughly five times the full test length

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  req;
  logic                  we;
  logic [ADDR_WIDTH-1:0] addr;
  logic [HOST_WIDTH-1:0] wdata;
  logic                  ack;
  logic [HOST_WIDTH-1:0] rdata;
  logic [GPIO_PAIRS-1:0] pad_n_in, pad_p_in;   // Board side driving into DUT
  logic [GPIO_PAIRS-1:0] pad_n_out, pad_p_out;
  logic [GPIO_PAIRS-1:0] pad_n_oe, pad_p_oe;
  logic                  irq;

  int          cycles = 0;
  int          errors = 0;       // Mismatches over the whole run
  int          test_errors = 0;  // Mismatches in the running test
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] lcg_state = 32'h69a1;

  gpio_top i_gpio_top (
    .clk_i      (clk),
    .rst_i      (rst),
    .req_i      (req),
    .we_i       (we),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .ack_o      (ack),
    .rdata_o    (rdata),
    .pad_n_i    (pad_n_in),
    .pad_p_i    (pad_p_in),
    .pad_n_o    (pad_n_out),
    .pad_p_o    (pad_p_out),
    .pad_n_oe_o (pad_n_oe),
    .pad_p_oe_o (pad_p_oe),
    .irq_o      (irq)
  );

  always #20 clk = ~clk; // 40 ns period

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, tests did not complete", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Numerical Recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Pair index of host bit k, four host bits per two-pair group
  function automatic int pad_pair(input int k);
    return 2 * (k / 4) + (k % 2);
  endfunction

  // Upper half of each group of four sits on P
  function automatic bit pad_on_p(input int k);
    return ((k % 4) >= 2);
  endfunction

  // Expected N or P pad vector for a host-side word
  function automatic logic [GPIO_PAIRS-1:0] pad_side(input logic [HOST_WIDTH-1:0] host,
                                                     input bit p_side);
    logic [GPIO_PAIRS-1:0] v;
    v = '0;
    for (int k = 0; k < GPIO_SIGS; k++) begin
      if (pad_on_p(k) == p_side) v[pad_pair(k)] = host[k];
    end
    return v;
  endfunction

  // Host view of the pads, upper bits left zero
  function automatic logic [HOST_WIDTH-1:0] host_from_pads(input logic [GPIO_PAIRS-1:0] n,
                                                           input logic [GPIO_PAIRS-1:0] p);
    logic [HOST_WIDTH-1:0] h;
    h = '0;
    for (int k = 0; k < GPIO_SIGS; k++) begin
      h[k] = pad_on_p(k) ? p[pad_pair(k)] : n[pad_pair(k)];
    end
    return h;
  endfunction

  task automatic report_mismatch(input string name, input logic [HOST_WIDTH-1:0] exp,
                                 input logic [HOST_WIDTH-1:0] act);
    $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
    errors++;
    test_errors++;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Sampled 1 ns after the edge, watchdog covers a dead DUT
  task automatic wait_ack(input logic level);
    while (ack !== level) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic bus_write(input logic [ADDR_WIDTH-1:0] a, input logic [HOST_WIDTH-1:0] d);
    @(posedge clk);
    #1;
    req   = 1'b1;
    we    = 1'b1;
    addr  = a;
    wdata = d;
    wait_ack(1'b1);
    req = 1'b0; // Phase 3
    we  = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic bus_read(input logic [ADDR_WIDTH-1:0] a, output logic [HOST_WIDTH-1:0] d);
    @(posedge clk);
    #1;
    req  = 1'b1;
    we   = 1'b0;
    addr = a;
    wait_ack(1'b1);
    d   = rdata; // Held while ack high
    req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic drive_pins(input logic [HOST_WIDTH-1:0] host);
    @(posedge clk);
    #1;
    pad_n_in = pad_side(host, 1'b0);
    pad_p_in = pad_side(host, 1'b1);
  endtask

  task automatic verify_reset_state();
    logic [HOST_WIDTH-1:0] rd;
    if (pad_n_oe !== '0) report_mismatch("pad_n_oe_o", '0, HOST_WIDTH'(pad_n_oe));
    if (pad_p_oe !== '0) report_mismatch("pad_p_oe_o", '0, HOST_WIDTH'(pad_p_oe));
    if (pad_n_out !== '0) report_mismatch("pad_n_o", '0, HOST_WIDTH'(pad_n_out));
    if (pad_p_out !== '0) report_mismatch("pad_p_o", '0, HOST_WIDTH'(pad_p_out));
    if (irq !== 1'b0) report_mismatch("irq_o", '0, HOST_WIDTH'(irq));
    bus_read(REG_TRI, rd);
    if (rd !== TRI_RESET) report_mismatch("rdata_o (REG_TRI)", TRI_RESET, rd);
    bus_read(REG_OUT, rd);
    if (rd !== OUT_RESET) report_mismatch("rdata_o (REG_OUT)", OUT_RESET, rd);
    close_test("reset defaults");
  endtask

  task automatic output_mapping();
    logic [HOST_WIDTH-1:0] out_pat, tri_pat, exp, rd;
    out_pat = 32'hC3A5_5A3C;
    tri_pat = 32'h5A00_F0F0;
    bus_write(REG_OUT, out_pat);
    bus_write(REG_TRI, tri_pat);
    exp = HOST_WIDTH'(pad_side(out_pat, 1'b0));
    if (pad_n_out !== exp[GPIO_PAIRS-1:0]) begin
      report_mismatch("pad_n_o", exp, HOST_WIDTH'(pad_n_out));
    end
    exp = HOST_WIDTH'(pad_side(out_pat, 1'b1));
    if (pad_p_out !== exp[GPIO_PAIRS-1:0]) begin
      report_mismatch("pad_p_o", exp, HOST_WIDTH'(pad_p_out));
    end
    exp = HOST_WIDTH'(pad_side(~tri_pat, 1'b0)); // Enable is inverse of tristate
    if (pad_n_oe !== exp[GPIO_PAIRS-1:0]) begin
      report_mismatch("pad_n_oe_o", exp, HOST_WIDTH'(pad_n_oe));
    end
    exp = HOST_WIDTH'(pad_side(~tri_pat, 1'b1));
    if (pad_p_oe !== exp[GPIO_PAIRS-1:0]) begin
      report_mismatch("pad_p_oe_o", exp, HOST_WIDTH'(pad_p_oe));
    end
    // Loopback bits only
    bus_read(REG_IN, rd);
    exp = out_pat & ~tri_pat;
    if (rd[HOST_WIDTH-1:GPIO_SIGS] !== exp[HOST_WIDTH-1:GPIO_SIGS]) begin
      report_mismatch("rdata_o (REG_IN upper)", exp >> GPIO_SIGS, rd >> GPIO_SIGS);
    end
    close_test("output mapping");
  endtask

  task automatic set_clear_aliases();
    logic [HOST_WIDTH-1:0] set_pat, clr_pat, exp, rd;
    set_pat = 32'h0F00_00F1;
    clr_pat = 32'h8001_0F03;
    exp     = 32'h9234_5678;
    bus_write(REG_OUT, exp);
    bus_write(REG_OUT_SET, set_pat);
    exp = exp | set_pat;
    bus_read(REG_OUT, rd);
    if (rd !== exp) report_mismatch("rdata_o (REG_OUT after set)", exp, rd);
    bus_write(REG_OUT_CLR, clr_pat);
    exp = exp & ~clr_pat;
    bus_read(REG_OUT, rd);
    if (rd !== exp) report_mismatch("rdata_o (REG_OUT after clear)", exp, rd);
    bus_write(REG_IN, '1); // Read-only, must not land anywhere
    bus_read(REG_OUT, rd);
    if (rd !== exp) report_mismatch("rdata_o (REG_OUT after REG_IN write)", exp, rd);
    bus_read(REG_OUT_SET, rd);
    if (rd !== '0) report_mismatch("rdata_o (REG_OUT_SET)", '0, rd);
    bus_read(REG_OUT_CLR, rd);
    if (rd !== '0) report_mismatch("rdata_o (REG_OUT_CLR)", '0, rd);
    close_test("set and clear");
  endtask

  task automatic input_readback();
    logic [HOST_WIDTH-1:0] exp, rd;
    bus_write(REG_TRI, '1); // All inputs, loopback reads zero
    for (int n = 0; n < 3; n++) begin
      drive_pins(lcg_next());
      wait_cycles(3); // Past the synchronizer
      exp = host_from_pads(pad_n_in, pad_p_in);
      bus_read(REG_IN, rd);
      if (rd !== exp) report_mismatch("rdata_o (REG_IN)", exp, rd);
    end
    close_test("input readback");
  endtask

  task automatic edge_interrupts();
    logic [HOST_WIDTH-1:0] en_pat, pol_pat, mask, exp_stat, old, nxt, rd;
    en_pat   = 32'h0000_00F0; // Falling-edge bits enabled only
    pol_pat  = 32'h0000_000F; // Bits 3..0 rising
    mask     = 32'h0000_0FFF;
    exp_stat = '0;
    old      = '0;
    drive_pins('0);
    wait_cycles(5);
    bus_write(REG_IRQ_STAT, '1); // Drop leftovers of earlier tests
    bus_write(REG_IRQ_EN, en_pat);
    bus_write(REG_IRQ_POL, pol_pat);
    bus_read(REG_IRQ_STAT, rd);
    if (rd !== '0) report_mismatch("rdata_o (REG_IRQ_STAT cleared)", '0, rd);
    // Rise, then fall
    for (int step = 0; step < 2; step++) begin
      nxt = (step == 0) ? mask : '0;
      drive_pins(nxt);
      wait_cycles(5);
      exp_stat = exp_stat | (pol_pat & nxt & ~old) | (~pol_pat & ~nxt & old);
      old = nxt;
      bus_read(REG_IRQ_STAT, rd);
      if (rd !== exp_stat) report_mismatch("rdata_o (REG_IRQ_STAT)", exp_stat, rd);
      if (irq !== (|(exp_stat & en_pat))) begin
        report_mismatch("irq_o", HOST_WIDTH'(|(exp_stat & en_pat)), HOST_WIDTH'(irq));
      end
    end
    bus_write(REG_IRQ_STAT, '1);
    bus_read(REG_IRQ_STAT, rd);
    if (rd !== '0) report_mismatch("rdata_o (REG_IRQ_STAT after W1C)", '0, rd);
    if (irq !== 1'b0) report_mismatch("irq_o", '0, HOST_WIDTH'(irq));
    close_test("interrupts");
  endtask

  task automatic random_traffic();
    logic [ADDR_WIDTH-1:0] addrs [4];
    logic [HOST_WIDTH-1:0] shadow [4]; // Testbench copy of the R/W registers
    logic [HOST_WIDTH-1:0] r, rd;
    logic [1:0]            sel;
    addrs[0] = REG_OUT;
    addrs[1] = REG_TRI;
    addrs[2] = REG_IRQ_EN;
    addrs[3] = REG_IRQ_POL;
    for (int i = 0; i < 4; i++) begin
      shadow[i] = lcg_next();
      bus_write(addrs[i], shadow[i]);
    end
    for (int n = 0; n < 40; n++) begin
      r   = lcg_next();
      sel = r[31:30]; // High bits, LCG low bits are weak
      if (r[29]) begin
        shadow[sel] = lcg_next();
        bus_write(addrs[sel], shadow[sel]);
      end else begin
        bus_read(addrs[sel], rd);
        if (rd !== shadow[sel]) report_mismatch("rdata_o (random read)", shadow[sel], rd);
      end
    end
    // Final sweep of all four
    for (int i = 0; i < 4; i++) begin
      bus_read(addrs[i], rd);
      if (rd !== shadow[i]) report_mismatch("rdata_o (final read)", shadow[i], rd);
    end
    close_test("random traffic");
  endtask

  initial begin
    rst      = 1'b1;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    wdata    = '0;
    pad_n_in = '0;
    pad_p_in = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    verify_reset_state();
    output_mapping();
    set_clear_aliases();
    input_readback();
    edge_interrupts();
    random_traffic();
    $display("Summary: %0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
design/gpio_cfg_pkg.sv
design/gpio_reg_pkg.sv
design/gpio_ctrl.sv
design/gpio_out_regs.sv
design/gpio_in_edge.sv
design/gpio_pin_map.sv
design/gpio_top.sv
tests/gpio_tb.sv

//--- Makefile
# Verilator build and run of the GPIO controller testbench

VERILATOR ?= verilator
TOP       ?= gpio_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
